// ==== bench/fetch_stage_tb.sv ====
/*
 * Testbench for the instruction fetch stage.
 * A random-latency bus memory answers fetches, reference functions predict
 * each redirect target and each IF-ID word, and a checker compares them.
 */

module fetch_stage_tb import fetch_pkg::*; ();

  // instructions checked over the run, the watchdog allows 20 cycles each
  localparam int unsigned NUM_TEST_INSTRS = 70;
  localparam int unsigned STALL_CYCLES    = 6;

  logic        clk_i;
  logic        rst_ni;
  ibus_req_t   ibus_req;
  ibus_rsp_t   ibus_rsp;
  logic        req_i;
  logic        pc_set_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  logic [5:0]  exc_cause_i;
  logic [31:0] branch_target_ex_i;
  csr_pcs_t    csrs;
  logic [31:0] boot_addr_i;
  logic        cheri_pmode_i;
  logic        debug_mode_i;
  pcc_cap_t    pcc_cap_i;
  logic        id_in_ready_i;
  logic        instr_valid_clear_i;
  logic        instr_valid_id_o;
  logic        instr_new_id_o;
  if_id_t      id_o;
  logic [31:0] pc_if_o;
  logic        if_busy_o;
  logic        csr_mtvec_init_o;

  integer      seed = 35584;

  // redirect handoff from stimulus to checker
  int          redir_seq;
  logic [31:0] redir_pc;
  logic        redir_pmode;
  logic        redir_dbg;
  pcc_cap_t    redir_cap;

  // checker state
  int          seen_seq;
  logic [31:0] exp_pc;
  logic        chk_pmode;
  logic        chk_dbg;
  pcc_cap_t    chk_cap;
  int          n_checked;
  int          chk_errors;
  int          bus_errors;
  int          stim_errors;

  fetch_stage fetch_stage_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .ibus_req_o          (ibus_req),
    .ibus_rsp_i          (ibus_rsp),
    .req_i               (req_i),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .exc_cause_i         (exc_cause_i),
    .branch_target_ex_i  (branch_target_ex_i),
    .csrs_i              (csrs),
    .boot_addr_i         (boot_addr_i),
    .cheri_pmode_i       (cheri_pmode_i),
    .debug_mode_i        (debug_mode_i),
    .pcc_cap_i           (pcc_cap_i),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .id_o                (id_o),
    .pc_if_o             (pc_if_o),
    .if_busy_o           (if_busy_o),
    .csr_mtvec_init_o    (csr_mtvec_init_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // addresses the memory answers with a bus error
  function automatic logic is_err_addr(logic [31:0] addr);
    return (addr == 32'h0000_3008) || (addr == 32'h0000_3010);
  endfunction

  function automatic logic [31:0] ref_next_pc(pc_sel_e sel, exc_pc_sel_e exc,
      logic [4:0] irq, logic [31:0] target, csr_pcs_t c, logic pmode, logic [31:0] boot);
    logic [31:0] w;
    logic [31:0] vec;
    logic [31:0] pc;
    w = c.mtvec;
    // vectored bit or legacy mode, 256-byte base
    if (w[0] || !pmode) begin
      vec = {w[31:8], 8'h00};
      if (exc == EXC_PC_IRQ) vec = vec + {25'd0, irq, 2'b00};
    end else begin
      vec = {w[31:2], 2'b00};
    end
    if (exc == EXC_PC_DBD) vec = 32'h1A11_0800;
    if (exc == EXC_PC_DBG_EXC) vec = 32'h1A11_0808;
    case (sel)
      PC_BOOT: pc = {boot[31:8], 8'h80};
      PC_JUMP: pc = target;
      PC_EXC:  pc = vec;
      PC_ERET: pc = c.mepc;
      default: pc = c.depc;
    endcase
    return pc;
  endfunction

  // expected IF-ID contents for a fetch at pc
  function automatic if_id_t ref_id(logic [31:0] pc, pcc_cap_t cap, logic pmode, logic dbg);
    if_id_t id;
    longint headroom;
    logic   on;
    on       = pmode && !dbg;
    headroom = longint'(cap.top33) - longint'(pc);
    id.rdata = pc ^ 32'hC0DE_0000;
    id.pc    = pc;
    id.cheri_acc_vio   = on && (!cap.perms[PERM_EX] || !cap.valid || (cap.otype != 3'd0));
    id.cheri_bound_vio = on && ((pc < cap.base32) || (headroom < 64'sd4));
    id.fetch_err = is_err_addr(pc) || id.cheri_acc_vio || id.cheri_bound_vio;
    return id;
  endfunction

  function automatic void print_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // bus memory
  //////////////////////////////////////////////////////////////////////

  initial begin : bus_memory
    logic        acc;
    logic [31:0] acc_addr;
    logic        pend;
    logic [31:0] pend_addr;
    int          cnt;
    logic        wait_gnt;
    logic [31:0] wait_addr;
    ibus_rsp  = '0;
    pend      = 1'b0;
    pend_addr = '0;
    cnt       = 0;
    wait_gnt  = 1'b0;
    wait_addr = '0;
    forever begin
      // handshake of this cycle is stable at the falling edge
      @(negedge clk_i);
      // an ungranted request keeps its address
      if (wait_gnt && ibus_req.req && (ibus_req.addr !== wait_addr)) begin
        $display("bus: request address changed before the grant at %0t", $time);
        bus_errors++;
      end
      acc       = ibus_req.req && ibus_rsp.gnt;
      acc_addr  = ibus_req.addr;
      wait_gnt  = ibus_req.req && !ibus_rsp.gnt;
      wait_addr = ibus_req.addr;
      @(posedge clk_i);
      #1;
      ibus_rsp.rvalid = 1'b0;
      ibus_rsp.err    = 1'b0;
      if (acc) begin
        pend      = 1'b1;
        pend_addr = acc_addr;
        // data 1 to 3 cycles after the grant
        cnt       = ($random(seed) & 3) % 3;
      end
      if (pend) begin
        if (cnt == 0) begin
          ibus_rsp.rvalid = 1'b1;
          ibus_rsp.rdata  = pend_addr ^ 32'hC0DE_0000;
          ibus_rsp.err    = is_err_addr(pend_addr);
          pend            = 1'b0;
        end else begin
          cnt = cnt - 1;
        end
      end
      // one outstanding access, random grant otherwise
      ibus_rsp.gnt = !pend && !ibus_rsp.rvalid && (($random(seed) & 3) != 0);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checker
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : compare_id
    if_id_t exp_id;
    // new stream after a redirect
    if (seen_seq != redir_seq) begin
      seen_seq  = redir_seq;
      exp_pc    = redir_pc;
      chk_pmode = redir_pmode;
      chk_dbg   = redir_dbg;
      chk_cap   = redir_cap;
    end
    if (rst_ni && instr_new_id_o && instr_valid_id_o) begin
      exp_id = ref_id(exp_pc, chk_cap, chk_pmode, chk_dbg);
      if (id_o.pc !== exp_id.pc) begin
        print_mismatch("id_o.pc", id_o.pc, exp_id.pc);
        chk_errors++;
      end
      if (id_o.rdata !== exp_id.rdata) begin
        print_mismatch("id_o.rdata", id_o.rdata, exp_id.rdata);
        chk_errors++;
      end
      if (id_o.fetch_err !== exp_id.fetch_err) begin
        print_mismatch("id_o.fetch_err", 32'(id_o.fetch_err), 32'(exp_id.fetch_err));
        chk_errors++;
      end
      if (id_o.cheri_acc_vio !== exp_id.cheri_acc_vio) begin
        print_mismatch("id_o.cheri_acc_vio", 32'(id_o.cheri_acc_vio),
                       32'(exp_id.cheri_acc_vio));
        chk_errors++;
      end
      if (id_o.cheri_bound_vio !== exp_id.cheri_bound_vio) begin
        print_mismatch("id_o.cheri_bound_vio", 32'(id_o.cheri_bound_vio),
                       32'(exp_id.cheri_bound_vio));
        chk_errors++;
      end
      exp_pc    = exp_pc + 32'd4;
      n_checked = n_checked + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic wait_instrs(input int n);
    int target;
    target = n_checked + n;
    wait (n_checked >= target);
  endtask

  task automatic redirect(input pc_sel_e sel, input exc_pc_sel_e exc, input logic [5:0] cause,
      input logic [31:0] target, input logic [31:0] mtvec, input logic pmode, input logic dbg,
      input pcc_cap_t cap);
    logic [31:0] next_pc;
    @(posedge clk_i);
    #1;
    pc_set_i           = 1'b1;
    pc_mux_i           = sel;
    exc_pc_mux_i       = exc;
    exc_cause_i        = cause;
    branch_target_ex_i = target;
    csrs.mtvec         = mtvec;
    cheri_pmode_i      = pmode;
    debug_mode_i       = dbg;
    pcc_cap_i          = cap;
    next_pc = ref_next_pc(sel, exc, cause[4:0], target, csrs, pmode, boot_addr_i);
    @(negedge clk_i);
    // init strobe only on boot
    if (csr_mtvec_init_o !== (sel == PC_BOOT)) begin
      print_mismatch("csr_mtvec_init_o", 32'(csr_mtvec_init_o), 32'(sel == PC_BOOT));
      stim_errors++;
    end
    @(posedge clk_i);
    #1;
    pc_set_i    = 1'b0;
    redir_pc    = next_pc;
    redir_pmode = pmode;
    redir_dbg   = dbg;
    redir_cap   = cap;
    redir_seq   = redir_seq + 1;
    @(negedge clk_i);
    if (csr_mtvec_init_o !== 1'b0) begin
      print_mismatch("csr_mtvec_init_o", 32'(csr_mtvec_init_o), 32'd0);
      stim_errors++;
    end
    // the redirect leaves a request pending or outstanding
    if (if_busy_o !== 1'b1) begin
      $display("redirect: fetch unit not busy after the redirect at %0t", $time);
      stim_errors++;
    end
  endtask

  task automatic jump_to(input logic [31:0] target, input logic pmode, input logic dbg,
      input pcc_cap_t cap);
    redirect(PC_JUMP, EXC_PC_EXC, 6'd0, target, csrs.mtvec, pmode, dbg, cap);
  endtask

  // stall ID right after a word enters it, check nothing moves, release
  task automatic stall_and_check();
    if_id_t      held_id;
    logic [31:0] held_pc;
    do begin
      @(posedge clk_i);
      #1;
    end while (!(instr_new_id_o && instr_valid_id_o));
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b0;
    // let an outstanding fetch land in the holding slot
    while (if_busy_o) @(negedge clk_i);
    held_id = id_o;
    held_pc = pc_if_o;
    if (held_pc !== exp_pc) begin
      print_mismatch("pc_if_o", held_pc, exp_pc);
      stim_errors++;
    end
    repeat (STALL_CYCLES) begin
      @(negedge clk_i);
      if (id_o !== held_id) begin
        $display("FAILED id_o: got %h, expected %h at %0t", id_o, held_id, $time);
        stim_errors++;
      end
      if (pc_if_o !== held_pc) begin
        print_mismatch("pc_if_o", pc_if_o, held_pc);
        stim_errors++;
      end
      if (ibus_req.req !== 1'b0 || if_busy_o !== 1'b0) begin
        $display("stall: a bus request was issued while ID was stalled at %0t", $time);
        stim_errors++;
      end
      if (instr_valid_id_o !== 1'b1 || instr_new_id_o !== 1'b0) begin
        $display("stall: ID valid dropped or new pulsed while stalled at %0t", $time);
        stim_errors++;
      end
    end
    // clear ID valid first while the word is still held
    @(posedge clk_i);
    #1;
    instr_valid_clear_i = 1'b1;
    @(posedge clk_i);
    #1;
    if (instr_valid_id_o !== 1'b0) begin
      $display("stall: ID valid still set after instr_valid_clear_i at %0t", $time);
      stim_errors++;
    end
    id_in_ready_i = 1'b1;
  endtask

  initial begin : stimulus
    pcc_cap_t cap_full;
    pcc_cap_t cap;
    pcc_cap_t cap_bad;
    cap_full        = '0;
    cap_full.top33  = 33'h1_0000_0000;
    cap_full.perms  = '1;
    cap_full.valid  = 1'b1;
    // every fault at once
    cap_bad         = '0;
    cap_bad.base32  = 32'hFFFF_0000;
    cap_bad.otype   = 3'd5;

    rst_ni              = 1'b0;
    req_i               = 1'b1;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    exc_cause_i         = '0;
    branch_target_ex_i  = '0;
    csrs.mepc           = 32'h0000_4400;
    csrs.depc           = 32'h0000_4800;
    csrs.mtvec          = 32'h0000_7700;
    boot_addr_i         = 32'h0000_1234;
    cheri_pmode_i       = 1'b0;
    debug_mode_i        = 1'b0;
    pcc_cap_i           = cap_full;
    id_in_ready_i       = 1'b1;
    instr_valid_clear_i = 1'b1;

    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // idle until the first redirect
    repeat (3) begin
      @(negedge clk_i);
      if (ibus_req.req || instr_valid_id_o || instr_new_id_o || csr_mtvec_init_o ||
          if_busy_o) begin
        $display("reset: fetch stage not idle before boot at %0t", $time);
        stim_errors++;
      end
    end

    // boot, then a stall in the middle of the stream
    redirect(PC_BOOT, EXC_PC_EXC, 6'd0, 32'h0, csrs.mtvec, 1'b0, 1'b0, cap_full);
    wait_instrs(6);
    stall_and_check();
    wait_instrs(4);

    // jumps, one with data outstanding, one with an ungranted request
    jump_to(32'h0000_2000, 1'b0, 1'b0, cap_full);
    wait_instrs(4);
    do @(negedge clk_i); while (!(if_busy_o && !ibus_req.req && !ibus_rsp.rvalid));
    jump_to(32'h0000_2400, 1'b0, 1'b0, cap_full);
    wait_instrs(3);
    do @(negedge clk_i); while (!(ibus_req.req && !ibus_rsp.gnt));
    jump_to(32'h0000_2800, 1'b0, 1'b0, cap_full);
    wait_instrs(3);

    // trap and debug returns
    redirect(PC_ERET, EXC_PC_EXC, 6'd0, 32'h0, csrs.mtvec, 1'b0, 1'b0, cap_full);
    wait_instrs(3);
    redirect(PC_DRET, EXC_PC_EXC, 6'd0, 32'h0, csrs.mtvec, 1'b0, 1'b0, cap_full);
    wait_instrs(3);

    // exception vectors, legacy then cheri decode
    redirect(PC_EXC, EXC_PC_EXC, 6'd0, 32'h0, 32'h0000_7700, 1'b0, 1'b0, cap_full);
    wait_instrs(3);
    redirect(PC_EXC, EXC_PC_IRQ, 6'd7, 32'h0, 32'h0000_7701, 1'b1, 1'b0, cap_full);
    wait_instrs(3);
    redirect(PC_EXC, EXC_PC_EXC, 6'd0, 32'h0, 32'h0000_7A34, 1'b1, 1'b0, cap_full);
    wait_instrs(2);
    redirect(PC_EXC, EXC_PC_IRQ, 6'd5, 32'h0, 32'h0000_7A34, 1'b1, 1'b0, cap_full);
    wait_instrs(2);
    redirect(PC_EXC, EXC_PC_DBD, 6'd0, 32'h0, 32'h0000_7A34, 1'b1, 1'b1, cap_full);
    wait_instrs(2);
    redirect(PC_EXC, EXC_PC_DBG_EXC, 6'd0, 32'h0, 32'h0000_7A34, 1'b1, 1'b1, cap_full);
    wait_instrs(2);

    // bus errors at 3008 and 3010
    jump_to(32'h0000_3000, 1'b1, 1'b0, cap_full);
    wait_instrs(6);

    // below base, then running off the top
    cap        = cap_full;
    cap.base32 = 32'h0000_5010;
    jump_to(32'h0000_5008, 1'b1, 1'b0, cap);
    wait_instrs(4);
    cap        = cap_full;
    cap.top33  = 33'h0_0000_6010;
    jump_to(32'h0000_6004, 1'b1, 1'b0, cap);
    wait_instrs(5);

    // permission, tag and seal faults
    cap                = cap_full;
    cap.perms[PERM_EX] = 1'b0;
    jump_to(32'h0000_6800, 1'b1, 1'b0, cap);
    wait_instrs(2);
    cap       = cap_full;
    cap.valid = 1'b0;
    jump_to(32'h0000_6840, 1'b1, 1'b0, cap);
    wait_instrs(2);
    cap       = cap_full;
    cap.otype = 3'd3;
    jump_to(32'h0000_6880, 1'b1, 1'b0, cap);
    wait_instrs(2);

    // no checks outside cheri mode or in debug
    jump_to(32'h0000_6900, 1'b0, 1'b0, cap_bad);
    wait_instrs(2);
    jump_to(32'h0000_6A00, 1'b1, 1'b1, cap_bad);
    wait_instrs(2);

    $display("errors: %0d compare, %0d bus, %0d other; instructions checked: %0d",
             chk_errors, bus_errors, stim_errors, n_checked);
    if (chk_errors == 0 && bus_errors == 0 && stim_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (NUM_TEST_INSTRS * 20) @(posedge clk_i);
    $display("timeout: tests did not finish within %0d cycles", NUM_TEST_INSTRS * 20);
    $display("errors: %0d compare, %0d bus, %0d other; instructions checked: %0d",
             chk_errors, bus_errors, stim_errors, n_checked);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== files.f ====
hdl/fetch_pkg.sv
hdl/pc_select.sv
hdl/fetch_unit.sv
hdl/pcc_fetch_check.sv
hdl/fetch_ctrl.sv
hdl/if_id_reg.sv
hdl/fetch_stage.sv
bench/fetch_stage_tb.sv

// ==== hdl/fetch_ctrl.sv ====
/*
 * Handshake control between the fetch unit and the ID stage.
 * Owns the ID valid and new flags and the IF-ID write enable.
 */

module fetch_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic fetch_valid_i,
  input  logic id_in_ready_i,
  input  logic pc_set_i,
  input  logic instr_valid_clear_i,
  output logic branch_req_o,
  output logic fetch_ready_o,
  output logic pipe_we_o,
  output logic instr_valid_id_o,
  output logic instr_new_id_o
);

  logic valid_q, valid_d;
  logic new_q, new_d;
  logic accept;

  // every redirect restarts the fetch unit
  assign branch_req_o = pc_set_i;

  // a stalled ID stage holds the word in the fetch unit
  assign fetch_ready_o = id_in_ready_i;

  // word moves into IF-ID
  assign accept    = fetch_valid_i & id_in_ready_i;
  assign pipe_we_o = accept;

  // valid sets on an unsquashed word and holds until cleared
  assign valid_d = (accept & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  // new pulses for any write, squashed or not
  assign new_d = accept;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= new_d;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

endmodule

// ==== hdl/fetch_pkg.sv ====
/*
 * Shared types and constants for the instruction fetch stage.
 * Holds the PC selectors, bus and pipeline structs, the mtvec decode
 * and the fixed debug entry addresses. Imported by the fetch modules.
 */

package fetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // selectors
  //////////////////////////////////////////////////////////////////////

  // source of the next PC on a redirect
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET,
    PC_DRET
  } pc_sel_e;

  // kind of handler taken on PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC,
    EXC_PC_IRQ,
    EXC_PC_DBD,
    EXC_PC_DBG_EXC
  } exc_pc_sel_e;

  //////////////////////////////////////////////////////////////////////
  // CSR views
  //////////////////////////////////////////////////////////////////////

  // legacy mtvec, 256-byte aligned base, mode bit 0 is vectored
  typedef struct packed {
    logic [23:0] base;
    logic [5:0]  rsvd;
    logic [1:0]  mode;
  } mtvec_legacy_t;

  // cheri mtvec, word aligned base
  typedef struct packed {
    logic [29:0] base;
    logic [1:0]  mode;
  } mtvec_cheri_t;

  // same csr word, decoded by mode bit and pmode
  typedef union packed {
    mtvec_legacy_t legacy;
    mtvec_cheri_t  cheri;
  } mtvec_u;

  typedef struct packed {
    logic [31:0] mepc;
    logic [31:0] depc;
    mtvec_u      mtvec;
  } csr_pcs_t;

  //////////////////////////////////////////////////////////////////////
  // program counter capability
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned PERMS_W = 12;
  // execute permission bit in perms
  localparam int unsigned PERM_EX = 10;

  typedef struct packed {
    logic [32:0]        top33;
    logic [31:0]        base32;
    logic [PERMS_W-1:0] perms;
    logic               valid;
    logic [2:0]         otype;
  } pcc_cap_t;

  //////////////////////////////////////////////////////////////////////
  // instruction bus and pipeline
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } ibus_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } ibus_rsp_t;

  // one returned word waiting in the fetch unit
  typedef struct packed {
    logic [31:0] rdata;
    logic [31:0] addr;
    logic        err;
  } fetch_word_t;

  // contents of the IF-ID register
  typedef struct packed {
    logic [31:0] rdata;
    logic [31:0] pc;
    logic        fetch_err;
    logic        cheri_acc_vio;
    logic        cheri_bound_vio;
  } if_id_t;

  // fixed entry points and boot offset
  localparam logic [31:0] DM_HALT_ADDR = 32'h1A11_0800;
  localparam logic [31:0] DM_EXC_ADDR  = 32'h1A11_0808;
  localparam logic [7:0]  BOOT_OFFSET  = 8'h80;
  localparam int unsigned INSTR_BYTES  = 4;

endpackage

// ==== hdl/fetch_stage.sv ====
/*
 * Instruction fetch stage top level.
 * Connects PC selection, the bus fetch unit, the PCC check, the handshake
 * control and the IF-ID register. Drop in as the IF stage of the core.
 */

module fetch_stage import fetch_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,

  // instruction bus
  output ibus_req_t   ibus_req_o,
  input  ibus_rsp_t   ibus_rsp_i,

  // core control
  input  logic        req_i,
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  logic [5:0]  exc_cause_i,
  input  logic [31:0] branch_target_ex_i,
  input  csr_pcs_t    csrs_i,
  input  logic [31:0] boot_addr_i,
  input  logic        cheri_pmode_i,
  input  logic        debug_mode_i,
  input  pcc_cap_t    pcc_cap_i,
  input  logic        id_in_ready_i,
  input  logic        instr_valid_clear_i,

  // towards ID
  output logic        instr_valid_id_o,
  output logic        instr_new_id_o,
  output if_id_t      id_o,
  output logic [31:0] pc_if_o,
  output logic        if_busy_o,
  output logic        csr_mtvec_init_o
);

  logic        branch_req;
  logic        fetch_ready;
  logic        pipe_we;
  logic        fetch_valid;
  logic [31:0] fetch_addr_n;
  fetch_word_t fetch_word;
  logic        cheri_acc_vio;
  logic        cheri_bound_vio;

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  fetch_ctrl fetch_ctrl_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .branch_req_o        (branch_req),
    .fetch_ready_o       (fetch_ready),
    .pipe_we_o           (pipe_we),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o)
  );

  // low five cause bits are the irq id
  pc_select pc_select_inst (
    .pc_mux_i         (pc_mux_i),
    .pc_set_i         (pc_set_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .irq_id_i         (exc_cause_i[4:0]),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_ex_i),
    .csrs_i           (csrs_i),
    .cheri_pmode_i    (cheri_pmode_i),
    .fetch_addr_n_o   (fetch_addr_n),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  //////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////

  fetch_unit fetch_unit_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .branch_i  (branch_req),
    .addr_i    (fetch_addr_n),
    .ready_i   (fetch_ready),
    .bus_rsp_i (ibus_rsp_i),
    .bus_req_o (ibus_req_o),
    .valid_o   (fetch_valid),
    .word_o    (fetch_word),
    .busy_o    (if_busy_o)
  );

  // checks the held word's address
  pcc_fetch_check pcc_fetch_check_inst (
    .pc_i          (fetch_word.addr),
    .pcc_cap_i     (pcc_cap_i),
    .cheri_pmode_i (cheri_pmode_i),
    .debug_mode_i  (debug_mode_i),
    .acc_vio_o     (cheri_acc_vio),
    .bound_vio_o   (cheri_bound_vio)
  );

  if_id_reg if_id_reg_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .we_i        (pipe_we),
    .word_i      (fetch_word),
    .acc_vio_i   (cheri_acc_vio),
    .bound_vio_i (cheri_bound_vio),
    .id_o        (id_o)
  );

  assign pc_if_o = fetch_word.addr;

endmodule

// ==== hdl/fetch_unit.sv ====
/*
 * Single-word instruction fetch unit.
 * Masters the instruction bus with at most one request outstanding and
 * holds one returned word until the pipeline accepts it.
 */

module fetch_unit import fetch_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  logic        branch_i,
  input  logic [31:0] addr_i,
  input  logic        ready_i,
  input  ibus_rsp_t   bus_rsp_i,
  output ibus_req_t   bus_req_o,
  output logic        valid_o,
  output fetch_word_t word_o,
  output logic        busy_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT,
    ST_HOLD
  } fu_state_e;

  fu_state_e   state_q, state_d;
  fu_state_e   resume;
  // bus address while requesting, next fetch address otherwise
  logic [31:0] addr_q, addr_d;
  // redirect target parked while an ungranted request is on the bus
  logic [31:0] stash_q, stash_d;
  logic        discard_q, discard_d;
  logic        armed_q, armed_d;
  fetch_word_t word_q, word_d;

  // where to go once the bus is free again
  assign resume = req_i ? ST_REQ : ST_IDLE;

  always_comb begin
    state_d   = state_q;
    addr_d    = addr_q;
    stash_d   = stash_q;
    discard_d = discard_q;
    armed_d   = armed_q | branch_i;
    word_d    = word_q;

    unique case (state_q)
      ST_IDLE: begin
        if (branch_i) begin
          addr_d  = addr_i;
          state_d = resume;
        end else if (req_i && armed_q) begin
          state_d = ST_REQ;
        end
      end
      ST_REQ: begin
        // address must stay put until granted
        if (bus_rsp_i.gnt) begin
          state_d = ST_WAIT;
          if (branch_i) begin
            addr_d    = addr_i;
            discard_d = 1'b1;
          end else if (discard_q) begin
            addr_d = stash_q;
          end
        end else if (branch_i) begin
          stash_d   = addr_i;
          discard_d = 1'b1;
        end
      end
      ST_WAIT: begin
        if (bus_rsp_i.rvalid) begin
          if (discard_q || branch_i) begin
            // stale response, drop it
            discard_d = 1'b0;
            state_d   = resume;
          end else begin
            word_d.rdata = bus_rsp_i.rdata;
            word_d.addr  = addr_q;
            word_d.err   = bus_rsp_i.err;
            addr_d       = addr_q + 32'(INSTR_BYTES);
            state_d      = ST_HOLD;
          end
        end else if (branch_i) begin
          discard_d = 1'b1;
        end
        if (branch_i) begin
          addr_d = addr_i;
        end
      end
      ST_HOLD: begin
        // a redirect wins over acceptance and drops the held word
        if (branch_i) begin
          addr_d  = addr_i;
          state_d = resume;
        end else if (ready_i) begin
          state_d = resume;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ST_IDLE;
      addr_q    <= '0;
      stash_q   <= '0;
      discard_q <= 1'b0;
      armed_q   <= 1'b0;
      word_q    <= '0;
    end else begin
      state_q   <= state_d;
      addr_q    <= addr_d;
      stash_q   <= stash_d;
      discard_q <= discard_d;
      armed_q   <= armed_d;
      word_q    <= word_d;
    end
  end

  assign bus_req_o.req  = (state_q == ST_REQ);
  assign bus_req_o.addr = addr_q;
  assign valid_o        = (state_q == ST_HOLD);
  assign word_o         = word_q;
  assign busy_o         = (state_q == ST_REQ) | (state_q == ST_WAIT);

endmodule

// ==== hdl/if_id_reg.sv ====
/*
 * IF-ID pipeline register.
 * Captures instruction, PC and fault flags when the ID stage takes a word,
 * and stays frozen otherwise.
 */

module if_id_reg import fetch_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        we_i,
  input  fetch_word_t word_i,
  input  logic        acc_vio_i,
  input  logic        bound_vio_i,
  output if_id_t      id_o
);

  if_id_t id_q;
  logic   any_err;

  // bus error and both cheri faults all mark the fetch as failed
  assign any_err = word_i.err | acc_vio_i | bound_vio_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q <= '0;
    end else if (we_i) begin
      id_q.rdata           <= word_i.rdata;
      id_q.pc              <= word_i.addr;
      id_q.fetch_err       <= any_err;
      // cheri causes kept apart for mcause selection in ID
      id_q.cheri_acc_vio   <= acc_vio_i;
      id_q.cheri_bound_vio <= bound_vio_i;
    end
  end

  assign id_o = id_q;

endmodule

// ==== hdl/pc_select.sv ====
/*
 * Next fetch address mux for redirects.
 * Picks boot, jump, return or handler address, decodes mtvec in legacy
 * or CHERI form and flags mtvec init on boot. Purely combinational.
 */

module pc_select import fetch_pkg::*; (
  input  pc_sel_e     pc_mux_i,
  input  logic        pc_set_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  logic [4:0]  irq_id_i,
  input  logic [31:0] boot_addr_i,
  input  logic [31:0] branch_target_i,
  input  csr_pcs_t    csrs_i,
  input  logic        cheri_pmode_i,
  output logic [31:0] fetch_addr_n_o,
  output logic        csr_mtvec_init_o
);

  logic        use_legacy;
  logic [31:0] exc_pc;

  // legacy decode when vectored mode is set or outside cheri mode
  assign use_legacy = csrs_i.mtvec.legacy.mode[0] | ~cheri_pmode_i;

  // handler address
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC: begin
        exc_pc = use_legacy ? {csrs_i.mtvec.legacy.base, 8'h00} :
                              {csrs_i.mtvec.cheri.base, 2'b00};
      end
      EXC_PC_IRQ: begin
        // vectored entry at base + 4*irq_id
        exc_pc = use_legacy ? {csrs_i.mtvec.legacy.base, 1'b0, irq_id_i, 2'b00} :
                              {csrs_i.mtvec.cheri.base, 2'b00};
      end
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
    endcase
  end

  // next fetch address
  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: fetch_addr_n_o = {boot_addr_i[31:8], BOOT_OFFSET};
      PC_JUMP: fetch_addr_n_o = branch_target_i;
      PC_EXC:  fetch_addr_n_o = exc_pc;
      // return from trap
      PC_ERET: fetch_addr_n_o = csrs_i.mepc;
      // return from debug mode
      PC_DRET: fetch_addr_n_o = csrs_i.depc;
      default: fetch_addr_n_o = {boot_addr_i[31:8], BOOT_OFFSET};
    endcase
  end

  // csr file loads mtvec from the boot address in the same cycle
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

// ==== hdl/pcc_fetch_check.sv ====
/*
 * CHERI check of the fetch PC against the program counter capability.
 * Flags permission/tag/seal faults and base or top bound faults.
 */

module pcc_fetch_check import fetch_pkg::*; (
  input  logic [31:0] pc_i,
  input  pcc_cap_t    pcc_cap_i,
  input  logic        cheri_pmode_i,
  input  logic        debug_mode_i,
  output logic        acc_vio_o,
  output logic        bound_vio_o
);

  logic [33:0] hdrm;
  logic        hdrm_ok;
  logic        base_ok;
  logic        chk_en;

  // no checks in legacy mode or while in debug
  assign chk_en = cheri_pmode_i & ~debug_mode_i;

  // bytes left between pc and top, sign bit set when pc is past top
  assign hdrm    = {1'b0, pcc_cap_i.top33} - {2'b00, pc_i};
  assign hdrm_ok = ~hdrm[33] & (hdrm[32:0] >= 33'(INSTR_BYTES));
  assign base_ok = (pc_i >= pcc_cap_i.base32);

  assign bound_vio_o = chk_en & ~(base_ok & hdrm_ok);

  // missing execute, cleared tag or sealed capability
  assign acc_vio_o = chk_en & (~pcc_cap_i.perms[PERM_EX] |
                               ~pcc_cap_i.valid |
                               (|pcc_cap_i.otype));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator.
# Exits nonzero unless the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f files.f --top-module fetch_stage_tb -Mdir obj_dir; then
  echo "verilator build failed"
  exit 1
fi

out="$(./obj_dir/Vfetch_stage_tb)"
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q -F '*** TEST PASSED ***'; then
  exit 0
fi
exit 1
